/* logic/spi_config.svh */
// SPI subsystem configuration
// Chip-select count, default SCK divider and register offsets
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// CS0 is the flash, CS1 the host device
`define SPI_NUM_CS 2

// Clock cycles per SCK half period
`define SPI_CLK_DIV 2

`define SPI_REG_TXDATA 4'h0
`define SPI_REG_RXDATA 4'h4
`define SPI_REG_STATUS 4'h8

`endif

/* logic/spi_pkg.sv */
// SPI subsystem types
// Register bus, OBI bus, pad bundle and host command structs
`include "spi_config.svh"

package spi_pkg;

  // Register bus
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
    logic        ready;
  } reg_rsp_t;

  // OBI bus
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  // Pad outputs of one engine
  typedef struct packed {
    logic                   sck;
    logic                   sck_en;
    logic [`SPI_NUM_CS-1:0] csb;
    logic [`SPI_NUM_CS-1:0] csb_en;
    logic [3:0]             sd;
    logic [3:0]             sd_en;
  } spi_pads_t;

  // One host byte transfer
  typedef struct packed {
    logic [7:0] data;
    logic       cs_sel;
    logic       hold_cs;
  } spi_cmd_t;

endpackage

/* logic/spi_ctrl.sv */
// SPI control block
// Decodes the register bus, picks the pad owner and muxes pads and MISO
`include "spi_config.svh"

module spi_ctrl
  import spi_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       use_spimemio_i,
  input  reg_req_t   reg_req_i,
  output reg_rsp_t   reg_rsp_o,
  output logic       host_start_o,
  output spi_cmd_t   host_cmd_o,
  input  logic       host_busy_i,
  input  logic       host_done_i,
  input  logic [7:0] host_rx_i,
  output logic       flash_en_o,
  input  logic       flash_busy_i,
  input  spi_pads_t  host_pads_i,
  input  spi_pads_t  flash_pads_i,
  output spi_pads_t  spi_pads_o,
  input  logic [3:0] spi_sd_i,
  output logic       host_miso_o,
  output logic       flash_miso_o
);

  logic       flash_mode_q;
  logic       rx_valid_q;
  logic [7:0] rx_byte_q;
  logic       rx_read;

  // Register decode, answered in the request cycle
  always_comb begin
    reg_rsp_o       = '0;
    reg_rsp_o.ready = reg_req_i.valid;
    host_start_o    = 1'b0;
    rx_read         = 1'b0;
    if (reg_req_i.valid) begin
      case (reg_req_i.addr)
        `SPI_REG_TXDATA: begin
          if (reg_req_i.write) begin
            if (host_busy_i || flash_mode_q) begin
              reg_rsp_o.error = 1'b1;
            end else begin
              host_start_o = 1'b1;
            end
          end
        end
        `SPI_REG_RXDATA: begin
          reg_rsp_o.error = reg_req_i.write;
          reg_rsp_o.rdata = {24'h0, rx_byte_q};
          rx_read         = !reg_req_i.write;
        end
        `SPI_REG_STATUS: begin
          reg_rsp_o.error = reg_req_i.write;
          reg_rsp_o.rdata = {29'h0, flash_mode_q, rx_valid_q, host_busy_i};
        end
        default: reg_rsp_o.error = 1'b1;
      endcase
    end
  end

  assign host_cmd_o.data    = reg_req_i.wdata[7:0];
  assign host_cmd_o.cs_sel  = reg_req_i.wdata[8];
  assign host_cmd_o.hold_cs = reg_req_i.wdata[9];

  // Ownership follows the request only while nothing is in flight
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      flash_mode_q <= 1'b0;
      rx_valid_q   <= 1'b0;
    end else begin
      if (!host_busy_i && !flash_busy_i && !host_start_o) begin
        flash_mode_q <= use_spimemio_i;
      end
      if (host_done_i) begin
        rx_valid_q <= 1'b1;
      end else if (rx_read) begin
        rx_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (host_done_i) begin
      rx_byte_q <= host_rx_i;
    end
  end

  assign flash_en_o = flash_mode_q;

  // Pads and MISO go to the owner only
  assign spi_pads_o   = flash_mode_q ? flash_pads_i : host_pads_i;
  assign host_miso_o  = flash_mode_q ? 1'b0 : spi_sd_i[1];
  assign flash_miso_o = flash_mode_q ? spi_sd_i[1] : 1'b0;

endmodule

/* logic/spi_byte_shifter.sv */
// SPI host byte engine
// Shifts one byte in SPI mode 0, MSB first, on the selected chip select
`include "spi_config.svh"

module spi_byte_shifter
  import spi_pkg::*;
#(
  parameter int CLK_DIV = `SPI_CLK_DIV
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       start_i,
  input  spi_cmd_t   cmd_i,
  output logic       busy_o,
  output logic       done_o,
  output logic [7:0] rx_byte_o,
  output spi_pads_t  pads_o,
  input  logic       miso_i
);

  localparam int NCS   = `SPI_NUM_CS;
  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  logic [DIV_W-1:0] div_cnt_q;
  logic [3:0]       half_cnt_q;
  logic             busy_q, last_q, done_q, sck_q, hold_q;
  logic [NCS-1:0]   csb_q;
  logic [7:0]       tx_q, rx_q;
  logic             tick;

  // One SCK edge every CLK_DIV cycles
  assign tick = busy_q && !last_q && (div_cnt_q == DIV_W'(CLK_DIV - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      last_q     <= 1'b0;
      done_q     <= 1'b0;
      sck_q      <= 1'b0;
      hold_q     <= 1'b0;
      csb_q      <= '1;
      div_cnt_q  <= '0;
      half_cnt_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i && !busy_q) begin
        busy_q     <= 1'b1;
        div_cnt_q  <= '0;
        half_cnt_q <= '0;
        hold_q     <= cmd_i.hold_cs;
        // Selecting a new device drops any held chip select
        csb_q      <= ~(NCS'(1) << cmd_i.cs_sel);
      end else if (last_q) begin
        busy_q <= 1'b0;
        last_q <= 1'b0;
        done_q <= 1'b1;
        if (!hold_q) begin
          csb_q <= '1;
        end
      end else if (tick) begin
        div_cnt_q  <= '0;
        sck_q      <= ~sck_q;
        half_cnt_q <= half_cnt_q + 4'd1;
        last_q     <= (half_cnt_q == 4'd15);
      end else if (busy_q) begin
        div_cnt_q <= div_cnt_q + DIV_W'(1);
      end
    end
  end

  // Sample on the rising edge, shift on the falling edge
  always_ff @(posedge clk_i) begin
    if (start_i && !busy_q) begin
      tx_q <= cmd_i.data;
    end else if (tick && sck_q) begin
      tx_q <= {tx_q[6:0], 1'b0};
    end
    if (tick && !sck_q) begin
      rx_q <= {rx_q[6:0], miso_i};
    end
  end

  assign busy_o    = busy_q;
  assign done_o    = done_q;
  assign rx_byte_o = rx_q;

  assign pads_o.sck    = sck_q;
  assign pads_o.sck_en = 1'b1;
  assign pads_o.csb    = csb_q;
  assign pads_o.csb_en = '1;
  assign pads_o.sd     = {3'b000, tx_q[7] & busy_q};
  assign pads_o.sd_en  = 4'b0001;

endmodule

/* logic/spi_flash_reader.sv */
// SPI flash reader
// Turns an OBI read into a 0x03 flash read and returns one 32-bit word
`include "spi_config.svh"

module spi_flash_reader
  import spi_pkg::*;
#(
  parameter int CLK_DIV = `SPI_CLK_DIV
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      enable_i,
  input  obi_req_t  obi_req_i,
  output obi_resp_t obi_resp_o,
  output logic      busy_o,
  output spi_pads_t pads_o,
  input  logic      miso_i
);

  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CMD,
    ST_DATA,
    ST_RESP
  } state_e;

  state_e           state_q;
  logic [DIV_W-1:0] div_cnt_q;
  logic [5:0]       half_cnt_q;
  logic             sck_q, csb_q, last_q, wr_q;
  logic [31:0]      tx_q, rx_q;
  logic             gnt, tick;

  assign gnt  = obi_req_i.req && (state_q == ST_IDLE) && enable_i;
  assign tick = ((state_q == ST_CMD) || (state_q == ST_DATA)) && !last_q &&
                (div_cnt_q == DIV_W'(CLK_DIV - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      sck_q      <= 1'b0;
      csb_q      <= 1'b1;
      last_q     <= 1'b0;
      wr_q       <= 1'b0;
      div_cnt_q  <= '0;
      half_cnt_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (gnt) begin
            wr_q       <= obi_req_i.we;
            div_cnt_q  <= '0;
            half_cnt_q <= '0;
            // Writes skip the flash and answer next cycle
            state_q    <= obi_req_i.we ? ST_RESP : ST_CMD;
            csb_q      <= obi_req_i.we;
          end
        end
        ST_CMD, ST_DATA: begin
          if (last_q) begin
            last_q  <= 1'b0;
            csb_q   <= 1'b1;
            state_q <= ST_RESP;
          end else if (tick) begin
            div_cnt_q  <= '0;
            sck_q      <= ~sck_q;
            half_cnt_q <= half_cnt_q + 6'd1;
            // 64 half periods per 32-bit phase
            if (half_cnt_q == 6'd63) begin
              if (state_q == ST_CMD) begin
                state_q <= ST_DATA;
              end else begin
                last_q <= 1'b1;
              end
            end
          end else begin
            div_cnt_q <= div_cnt_q + DIV_W'(1);
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Command and address out, data in
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      tx_q <= {8'h03, obi_req_i.addr[23:0]};
    end else if (tick && sck_q) begin
      tx_q <= {tx_q[30:0], 1'b0};
    end
    if (tick && !sck_q && (state_q == ST_DATA)) begin
      rx_q <= {rx_q[30:0], miso_i};
    end
  end

  // First byte off the wire lands in bits 7:0
  assign obi_resp_o.gnt    = gnt;
  assign obi_resp_o.rvalid = (state_q == ST_RESP);
  assign obi_resp_o.rdata  = wr_q ? 32'h0 :
                             {rx_q[7:0], rx_q[15:8], rx_q[23:16], rx_q[31:24]};

  // Counts the grant cycle so ownership cannot move under a new read
  assign busy_o = (state_q != ST_IDLE) || gnt;

  assign pads_o.sck    = sck_q;
  assign pads_o.sck_en = 1'b1;
  assign pads_o.csb    = {{(`SPI_NUM_CS - 1){1'b1}}, csb_q};
  assign pads_o.csb_en = '1;
  assign pads_o.sd     = {3'b000, tx_q[31] & (state_q == ST_CMD)};
  assign pads_o.sd_en  = 4'b0001;

endmodule

/* logic/spi_subsystem.sv */
// SPI subsystem top
// Flash reader and host byte engine sharing one set of SPI pads
module spi_subsystem
  import spi_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       use_spimemio_i,
  input  reg_req_t   reg_req_i,
  output reg_rsp_t   reg_rsp_o,
  input  obi_req_t   obi_req_i,
  output obi_resp_t  obi_resp_o,
  output spi_pads_t  spi_pads_o,
  input  logic [3:0] spi_sd_i
);

  logic       host_start, host_busy, host_done, host_miso;
  logic [7:0] host_rx;
  spi_cmd_t   host_cmd;
  logic       flash_en, flash_busy, flash_miso;
  spi_pads_t  host_pads, flash_pads;

  spi_ctrl spi_ctrl_i (
    .clk_i,
    .rst_n_i,
    .use_spimemio_i,
    .reg_req_i,
    .reg_rsp_o,
    .host_start_o (host_start),
    .host_cmd_o   (host_cmd),
    .host_busy_i  (host_busy),
    .host_done_i  (host_done),
    .host_rx_i    (host_rx),
    .flash_en_o   (flash_en),
    .flash_busy_i (flash_busy),
    .host_pads_i  (host_pads),
    .flash_pads_i (flash_pads),
    .spi_pads_o,
    .spi_sd_i,
    .host_miso_o  (host_miso),
    .flash_miso_o (flash_miso)
  );

  spi_byte_shifter spi_byte_shifter_i (
    .clk_i,
    .rst_n_i,
    .start_i   (host_start),
    .cmd_i     (host_cmd),
    .busy_o    (host_busy),
    .done_o    (host_done),
    .rx_byte_o (host_rx),
    .pads_o    (host_pads),
    .miso_i    (host_miso)
  );

  spi_flash_reader spi_flash_reader_i (
    .clk_i,
    .rst_n_i,
    .enable_i (flash_en),
    .obi_req_i,
    .obi_resp_o,
    .busy_o   (flash_busy),
    .pads_o   (flash_pads),
    .miso_i   (flash_miso)
  );

endmodule

/* bench/spi_flash_model.sv */
// SPI device model for the testbench
// CS0 answers 0x03 reads with (addr XOR 0x5A) per byte, CS1 echoes its previous byte
`include "spi_config.svh"

module spi_flash_model (
  input  logic                   sck_i,
  input  logic [`SPI_NUM_CS-1:0] csb_i,
  input  logic                   mosi_i,
  output logic                   miso_o,
  output logic [7:0]             last_rx_o,
  output logic [31:0]            cmd_o
);

  logic [31:0] cmd_q     = 32'h0;
  logic [6:0]  flash_cnt = 7'd0;
  logic        flash_bit = 1'b0;
  logic [6:0]  data_idx;
  logic [7:0]  data_byte;
  logic [2:0]  echo_cnt  = 3'd0;
  logic [7:0]  echo_rx   = 8'h0;
  logic [7:0]  echo_tx   = 8'h0;
  logic [7:0]  echo_last = 8'hA5;

  // Flash takes 32 bits of command and address, then sends data
  always @(posedge sck_i or posedge csb_i[0]) begin
    if (csb_i[0]) begin
      flash_cnt <= 7'd0;
    end else begin
      if (flash_cnt < 7'd32) begin
        cmd_q <= {cmd_q[30:0], mosi_i};
      end
      flash_cnt <= flash_cnt + 7'd1;
    end
  end

  assign data_idx  = flash_cnt - 7'd32;
  assign data_byte = (cmd_q[7:0] + {5'b0, data_idx[5:3]}) ^ 8'h5A;

  // Mode 0 device output changes on the falling edge
  always @(negedge sck_i) begin
    if (!csb_i[0] && flash_cnt >= 7'd32) begin
      flash_bit <= data_byte[3'd7 - data_idx[2:0]];
    end
  end

  always @(posedge sck_i) begin
    if (!csb_i[1]) begin
      echo_rx  <= {echo_rx[6:0], mosi_i};
      echo_cnt <= echo_cnt + 3'd1;
      if (echo_cnt == 3'd7) begin
        echo_last <= {echo_rx[6:0], mosi_i};
      end
    end
  end

  // Every byte on CS1 starts with the byte received before it
  always @(negedge sck_i or negedge csb_i[1]) begin
    if (!csb_i[1]) begin
      if (echo_cnt == 3'd0) begin
        echo_tx <= echo_last;
      end else begin
        echo_tx <= {echo_tx[6:0], 1'b0};
      end
    end
  end

  assign miso_o    = !csb_i[0] ? flash_bit : (!csb_i[1] ? echo_tx[7] : 1'b0);
  assign last_rx_o = echo_last;

  // Command and address of the last flash read
  assign cmd_o     = cmd_q;

endmodule

/* bench/spi_subsystem_asserts.sv */
// SPI subsystem protocol checks
// Chip-select exclusivity, chip-select timing against SCK, OBI response order
module spi_subsystem_asserts
  import spi_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  spi_pads_t pads_i,
  input  obi_resp_t obi_resp_i
);

  logic pending_q;

  // One OBI transaction in flight at most
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
    end else if (obi_resp_i.gnt) begin
      pending_q <= 1'b1;
    end else if (obi_resp_i.rvalid) begin
      pending_q <= 1'b0;
    end
  end

  one_csb_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $countones(~pads_i.csb) <= 1)
    else $error("more than one chip select is low");

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    obi_resp_i.rvalid |-> pending_q)
    else $error("rvalid without an open granted request");

  csb_sck_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$stable(pads_i.csb) |-> (!pads_i.sck && !$past(pads_i.sck)))
    else $error("chip select changed while SCK was high");

endmodule

bind spi_subsystem spi_subsystem_asserts asserts_i (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .pads_i     (spi_pads_o),
  .obi_resp_i (obi_resp_o)
);

/* bench/spi_subsystem_tb.sv */
// SPI subsystem testbench
// Directed host, flash, error and ownership tests against a behavioral SPI device
`include "spi_config.svh"

module spi_subsystem_tb
  import spi_pkg::*;
();

  // Longest test is the random mix, about 8 flash reads and 8 host bytes
  localparam int TIMEOUT_CYCLES = 40000;
  localparam spi_pads_t IDLE_PADS = '{sck: 1'b0, sck_en: 1'b1, csb: '1, csb_en: '1,
                                      sd: 4'h0, sd_en: 4'h1};

  logic        clk;
  logic        rst_n;
  logic        use_spimemio;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;
  obi_req_t    obi_req;
  obi_resp_t   obi_resp;
  spi_pads_t   spi_pads;
  logic [3:0]  spi_sd;
  logic        model_miso;
  logic [7:0]  model_rx;
  logic [31:0] model_cmd;
  logic [7:0]  echo_expect;
  int          errors;
  int          tests;
  int          seed;
  int          cycle_cnt;
  int          csb_falls = 0;

  spi_subsystem dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .use_spimemio_i (use_spimemio),
    .reg_req_i      (reg_req),
    .reg_rsp_o      (reg_rsp),
    .obi_req_i      (obi_req),
    .obi_resp_o     (obi_resp),
    .spi_pads_o     (spi_pads),
    .spi_sd_i       (spi_sd)
  );

  spi_flash_model flash_model (
    .sck_i     (spi_pads.sck),
    .csb_i     (spi_pads.csb),
    .mosi_i    (spi_pads.sd[0]),
    .miso_o    (model_miso),
    .last_rx_o (model_rx),
    .cmd_o     (model_cmd)
  );

  assign spi_sd = {2'b00, model_miso, 1'b0};

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge spi_pads.csb[0] or negedge spi_pads.csb[1]) begin
    csb_falls++;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Run stopped after %0d cycles without finishing", cycle_cnt);
    $display("TB FAILED");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    $display("%s: %s", name, (errors == errs_before) ? "ok" : "failed");
  endtask

  // Expected flash word, first byte in bits 7:0
  function automatic logic [31:0] flash_word(input logic [23:0] addr);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) begin
      w[8*i +: 8] = (addr[7:0] + 8'(i)) ^ 8'h5A;
    end
    return w;
  endfunction

  task automatic reg_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    #1;
    reg_req = '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
    @(negedge clk);
    if (!reg_rsp.ready) begin
      report_failure("register bus gave no ready");
    end
    rdata = reg_rsp.rdata;
    err   = reg_rsp.error;
    @(posedge clk);
    #1;
    reg_req = '0;
  endtask

  task automatic obi_access(input logic we, input logic [31:0] addr, output logic [31:0] rdata);
    @(posedge clk);
    #1;
    obi_req = '{req: 1'b1, we: we, be: 4'hF, addr: addr, wdata: 32'h0};
    @(negedge clk);
    while (!obi_resp.gnt) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    obi_req = '0;
    @(negedge clk);
    while (!obi_resp.rvalid) begin
      @(negedge clk);
    end
    rdata = obi_resp.rdata;
  endtask

  // One flash read, checked for data and for the command seen on the wire
  task automatic check_flash_read(input logic [23:0] addr, input string name);
    logic [31:0] rd;
    obi_access(1'b0, {8'h0, addr}, rd);
    if (rd !== flash_word(addr)) begin
      report_mismatch(name, flash_word(addr), rd);
    end
    if (model_cmd !== {8'h03, addr}) begin
      report_mismatch("flash model command word", {8'h03, addr}, model_cmd);
    end
  endtask

  task automatic wait_host_idle;
    logic [31:0] rd;
    logic        err;
    reg_access(1'b0, `SPI_REG_STATUS, 32'h0, rd, err);
    while (rd[0] !== 1'b0) begin
      reg_access(1'b0, `SPI_REG_STATUS, 32'h0, rd, err);
    end
  endtask

  task automatic wait_mode(input logic m);
    logic [31:0] rd;
    logic        err;
    reg_access(1'b0, `SPI_REG_STATUS, 32'h0, rd, err);
    while (rd[2] !== m) begin
      reg_access(1'b0, `SPI_REG_STATUS, 32'h0, rd, err);
    end
  endtask

  task automatic set_mode(input logic m);
    @(posedge clk);
    #1;
    use_spimemio = m;
    wait_mode(m);
  endtask

  // Always on CS1, the echo device
  task automatic host_transfer(input logic [7:0] data, input logic hold);
    logic [31:0] rd;
    logic        err;
    reg_access(1'b1, `SPI_REG_TXDATA, {22'h0, hold, 1'b1, data}, rd, err);
    if (err !== 1'b0) begin
      report_failure("TXDATA write was refused");
    end
    wait_host_idle();
  endtask

  task automatic check_echo(input logic [7:0] sent);
    logic [31:0] rd;
    logic        err;
    reg_access(1'b0, `SPI_REG_RXDATA, 32'h0, rd, err);
    if (rd !== {24'h0, echo_expect}) begin
      report_mismatch("reg_rsp.rdata (RXDATA)", {24'h0, echo_expect}, rd);
    end
    if (model_rx !== sent) begin
      report_mismatch("model rx byte", 32'(sent), 32'(model_rx));
    end
    echo_expect = sent;
  endtask

  task automatic check_reset_state;
    logic [31:0] rd;
    logic        err;
    int          errs;
    errs = errors;
    @(negedge clk);
    if (spi_pads !== IDLE_PADS) begin
      report_mismatch("spi_pads", 32'(IDLE_PADS), 32'(spi_pads));
    end
    if ({obi_resp.gnt, obi_resp.rvalid} !== 2'b00) begin
      report_mismatch("obi_resp.gnt/rvalid", 32'h0, 32'({obi_resp.gnt, obi_resp.rvalid}));
    end
    reg_access(1'b0, `SPI_REG_STATUS, 32'h0, rd, err);
    if (rd !== 32'h0) begin
      report_mismatch("reg_rsp.rdata (STATUS)", 32'h0, rd);
    end
    if (err !== 1'b0) begin
      report_mismatch("reg_rsp.error (STATUS)", 32'h0, 32'(err));
    end
    report_test("reset state", errs);
  endtask

  task automatic run_host_transfers;
    logic [31:0] rd;
    logic        err;
    int          errs;
    errs = errors;
    host_transfer(8'h3C, 1'b1);
    @(negedge clk);
    if (spi_pads.csb !== 2'b01) begin
      report_mismatch("spi_pads.csb (held)", 32'h1, 32'(spi_pads.csb));
    end
    check_echo(8'h3C);
    host_transfer(8'hC3, 1'b0);
    @(negedge clk);
    if (spi_pads.csb !== 2'b11) begin
      report_mismatch("spi_pads.csb (released)", 32'h3, 32'(spi_pads.csb));
    end
    reg_access(1'b0, `SPI_REG_STATUS, 32'h0, rd, err);
    if (rd !== 32'h2) begin
      report_mismatch("reg_rsp.rdata (STATUS rx_valid)", 32'h2, rd);
    end
    check_echo(8'hC3);
    reg_access(1'b0, `SPI_REG_STATUS, 32'h0, rd, err);
    if (rd !== 32'h0) begin
      report_mismatch("reg_rsp.rdata (STATUS after read)", 32'h0, rd);
    end
    report_test("host transfer", errs);
  endtask

  task automatic run_flash_reads;
    logic [23:0] addrs [0:3] = '{24'h000000, 24'h0000FE, 24'h123456, 24'hABCDEF};
    logic [31:0] rd;
    int          errs;
    errs = errors;
    set_mode(1'b1);
    for (int i = 0; i < 4; i++) begin
      check_flash_read(addrs[i], "obi_resp.rdata");
    end
    obi_access(1'b1, 32'h40, rd);
    if (rd !== 32'h0) begin
      report_mismatch("obi_resp.rdata (write ack)", 32'h0, rd);
    end
    set_mode(1'b0);
    report_test("flash read", errs);
  endtask

  task automatic check_error_responses;
    logic [31:0] rd;
    logic        err;
    int          falls;
    int          errs;
    errs  = errors;
    falls = csb_falls;
    reg_access(1'b1, `SPI_REG_TXDATA, 32'h15A, rd, err);
    reg_access(1'b1, `SPI_REG_TXDATA, 32'h1FF, rd, err);
    if (err !== 1'b1) begin
      report_mismatch("reg_rsp.error (TXDATA while busy)", 32'h1, 32'(err));
    end
    wait_host_idle();
    if (csb_falls - falls != 1) begin
      report_mismatch("chip select falls (busy)", 32'h1, 32'(csb_falls - falls));
    end
    check_echo(8'h5A);
    // Unknown offset while the host owns the pads
    falls = csb_falls;
    reg_access(1'b1, 4'hC, 32'h1A5, rd, err);
    if (err !== 1'b1) begin
      report_mismatch("reg_rsp.error (unknown offset)", 32'h1, 32'(err));
    end
    set_mode(1'b1);
    reg_access(1'b1, `SPI_REG_TXDATA, 32'h1A5, rd, err);
    if (err !== 1'b1) begin
      report_mismatch("reg_rsp.error (TXDATA in flash mode)", 32'h1, 32'(err));
    end
    reg_access(1'b0, `SPI_REG_STATUS, 32'h0, rd, err);
    if (rd !== 32'h4) begin
      report_mismatch("reg_rsp.rdata (STATUS after refused writes)", 32'h4, rd);
    end
    if (csb_falls != falls) begin
      report_mismatch("chip select falls (refused)", 32'h0, 32'(csb_falls - falls));
    end
    set_mode(1'b0);
    report_test("error responses", errs);
  endtask

  task automatic check_deferred_switch;
    logic [31:0] rd;
    logic        err;
    int          errs;
    errs = errors;
    reg_access(1'b1, `SPI_REG_TXDATA, 32'h196, rd, err);
    @(posedge clk);
    #1;
    use_spimemio = 1'b1;
    reg_access(1'b0, `SPI_REG_STATUS, 32'h0, rd, err);
    if (rd !== 32'h1) begin
      report_mismatch("reg_rsp.rdata (STATUS mid transfer)", 32'h1, rd);
    end
    wait_host_idle();
    wait_mode(1'b1);
    reg_access(1'b0, `SPI_REG_STATUS, 32'h0, rd, err);
    if (rd !== 32'h6) begin
      report_mismatch("reg_rsp.rdata (STATUS after switch)", 32'h6, rd);
    end
    check_echo(8'h96);
    set_mode(1'b0);
    report_test("deferred switch", errs);
  endtask

  // Even steps are host bytes, odd steps flash reads
  task automatic run_random_mix;
    logic [31:0] rnd;
    int          errs;
    errs = errors;
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      if (i % 2 == 0) begin
        set_mode(1'b0);
        host_transfer(rnd[7:0], 1'b0);
        check_echo(rnd[7:0]);
      end else begin
        set_mode(1'b1);
        check_flash_read(rnd[31:8], "obi_resp.rdata (random)");
      end
    end
    set_mode(1'b0);
    report_test("random mix", errs);
  endtask

  initial begin
    seed         = 32'hda0e1324;
    errors       = 0;
    tests        = 0;
    echo_expect  = 8'hA5;
    rst_n        = 1'b0;
    use_spimemio = 1'b0;
    reg_req      = '0;
    obi_req      = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_reset_state();
    run_host_transfers();
    run_flash_reads();
    check_error_responses();
    check_deferred_switch();
    run_random_mix();
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+logic
logic/spi_pkg.sv
logic/spi_ctrl.sv
logic/spi_byte_shifter.sv
logic/spi_flash_reader.sv
logic/spi_subsystem.sv
bench/spi_flash_model.sv
bench/spi_subsystem_asserts.sv
bench/spi_subsystem_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Mdir obj_dir --top-module spi_subsystem_tb -f sim.f
	@out="$$(./obj_dir/Vspi_subsystem_tb)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
